//--- logic/video_timing_pkg.sv
/*
  Video timing definitions for the background display processor.
  Raster size, render window, sync positions, pixel types and the
  16-entry RGB palette.
*/
`default_nettype none

package video_timing_pkg;

  typedef logic [8:0]  raster_t;     // Row or column count
  typedef logic [3:0]  color_idx_t;  // Palette index
  typedef logic [23:0] rgb_t;        // {red, green, blue}

  // Raster size
  localparam raster_t num_rows = 9'd263;
  localparam raster_t num_cols = 9'd260;

  // Render window, 208 x 232
  localparam raster_t first_row_render = 9'd16;
  localparam raster_t last_row_render  = 9'd247;
  localparam raster_t first_col_render = 9'd23;
  localparam raster_t last_col_render  = 9'd230;

  localparam raster_t first_row_vsync = 9'd257;
  localparam raster_t last_row_vsync  = 9'd259;
  localparam raster_t first_col_hsync = 9'd240;
  localparam raster_t last_col_hsync  = 9'd259;

  localparam int pipe_latency = 3;  // Raster position to RGB and sync

  localparam color_idx_t border_color = 4'd1;  // Black

  // RGB connector levels; brightness sags as R+G+B rises
  localparam rgb_t palette [16] = '{
    24'h0000A0, 24'h000000, 24'h0000F5, 24'hA000EB,
    24'h00F500, 24'h96EB96, 24'h00EBEB, 24'h00A000,
    24'hF50000, 24'hEBA000, 24'hEB00EB, 24'hEB9696,
    24'hEBEB00, 24'hA0A000, 24'h969696, 24'hE1E1E1
  };

endpackage

`default_nettype wire

//--- logic/host_bus_pkg.sv
/*
  Host bus definitions. Address map, decoded region, control register
  indices and field positions, memory sizes.
*/
`default_nettype none

package host_bus_pkg;

  typedef logic [12:0] addr_t;

  typedef enum logic [1:0] {
    region_none,
    region_bgm,   // 0x1000 - 0x11FF
    region_reg    // 0x1400 - 0x15FF
  } bus_region_t;

  // Address bits 12:9 of each region
  localparam logic [3:0] bgm_page = 4'h8;
  localparam logic [3:0] reg_page = 4'hA;

  // Control register indices
  localparam int reg_mode     = 0;
  localparam int reg_bm_color = 1;
  localparam int reg_window   = 2;
  localparam int reg_ch_color = 3;

  // Register 0 bits
  localparam int bm_enable_bit = 0;
  localparam int bm_lores_bit  = 1;
  localparam int invert_x_bit  = 6;
  localparam int invert_y_bit  = 7;

  // Nibble fields of registers 1 to 3
  localparam int bg_nibble_lsb = 0;
  localparam int fg_nibble_lsb = 4;
  localparam int xmax_lsb      = 0;
  localparam int ymax_lsb      = 4;

  localparam logic [7:0] reg_read_value = 8'hFF;

  localparam int chr_depth  = 1024;
  localparam int bgm_words  = 128;
  localparam int chr_addr_w = $clog2(chr_depth);
  localparam int bgm_addr_w = $clog2(bgm_words);

endpackage

`default_nettype wire

//--- logic/raster_timing.sv
/*
  Raster counter and sync generator.
  263 rows by 260 columns, one column per clock. DE, HS, VS and VBL
  are delayed to line up with the RGB pipeline.
*/
`default_nettype none
`timescale 1ns/100ps

module raster_timing import video_timing_pkg::*; (
  input  wire      CLK,
  input  wire      reset,
  output raster_t  row,
  output raster_t  col,
  output logic     vsync_start,
  output logic     render_px,
  output logic     de,
  output logic     hs,
  output logic     vs,
  output logic     vbl
);

  logic render_row, render_col;
  logic [pipe_latency-1:0] de_sr, hs_sr, vs_sr, vbl_sr;

  always_ff @(posedge CLK) begin
    if (reset) begin
      row <= '0;
      col <= '0;
    end else if (col == num_cols - 9'd1) begin
      col <= '0;
      row <= (row == num_rows - 9'd1) ? '0 : row + 9'd1;  // Frame wrap
    end else begin
      col <= col + 9'd1;
    end
  end

  assign render_row  = (row >= first_row_render) && (row <= last_row_render);
  assign render_col  = (col >= first_col_render) && (col <= last_col_render);
  assign vsync_start = (row == first_row_vsync) && (col == '0);  // Shadow regs go live

  // Delay lines, newest stage in bit 0
  always_ff @(posedge CLK) begin
    if (reset) begin
      de_sr  <= '0;
      hs_sr  <= '0;
      vs_sr  <= '0;
      vbl_sr <= '1;
    end else begin
      de_sr  <= {de_sr[pipe_latency-2:0], render_row & render_col};
      hs_sr  <= {hs_sr[pipe_latency-2:0], (col >= first_col_hsync) && (col <= last_col_hsync)};
      vs_sr  <= {vs_sr[pipe_latency-2:0], (row >= first_row_vsync) && (row <= last_row_vsync)};
      vbl_sr <= {vbl_sr[pipe_latency-2:0], ~render_row};
    end
  end

  assign render_px = de_sr[pipe_latency-2];  // One stage early for color_gen
  assign de        = de_sr[pipe_latency-1];
  assign hs        = hs_sr[pipe_latency-1];
  assign vs        = vs_sr[pipe_latency-1];
  assign vbl       = vbl_sr[pipe_latency-1];

endmodule

`default_nettype wire

//--- logic/host_port.sv
/*
  Host port. Decodes the address, paces the valid/ready handshake
  around the renderer's BGM slot, holds the shadow and active
  control registers and returns read data two cycles after a read.
*/
`default_nettype none
`timescale 1ns/100ps

module host_port import host_bus_pkg::*, video_timing_pkg::*; (
  input  wire                   CLK,
  input  wire                   reset,
  input  wire                   bus_valid,
  output logic                  bus_ready,
  input  wire                   bus_write,
  input  wire addr_t            bus_addr,
  input  wire [7:0]             bus_wdata,
  output logic                  bus_rvalid,
  output logic [7:0]            bus_rdata,
  input  wire raster_t          col,
  input  wire                   vsync_start,
  output logic                  bgm_host_en,
  output logic [bgm_addr_w-1:0] bgm_host_addr,
  output logic [3:0]            bgm_host_we,
  output logic [7:0]            bgm_host_wdata,
  input  wire [31:0]            bgm_host_rdata,
  output logic [7:0]            ctl_mode,
  output logic [7:0]            ctl_bm_color,
  output logic [7:0]            ctl_window,
  output logic [7:0]            ctl_ch_color
);

  bus_region_t      region, rd_region_q;
  logic             xfer, rd_pend_q;
  logic [1:0]       rd_lane_q;
  logic [3:0][7:0]  shadow_q, active_q;

  always_comb begin
    case (bus_addr[12:9])
      bgm_page: region = region_bgm;
      reg_page: region = region_reg;
      default:  region = region_none;
    endcase
  end

  // Ready drops for column phase 3, the renderer's BGM slot
  assign bus_ready = ~reset & (col[2:0] != 3'd3);

  assign xfer           = bus_valid & bus_ready;
  assign bgm_host_en    = xfer && (region == region_bgm);
  assign bgm_host_addr  = bus_addr[bgm_addr_w+1:2];
  assign bgm_host_we    = (bgm_host_en & bus_write) ? (4'b0001 << bus_addr[1:0]) : 4'b0000;
  assign bgm_host_wdata = bus_wdata;

  ////////////////////////////////
  // Control registers

  always_ff @(posedge CLK) begin
    if (reset) begin
      shadow_q <= '0;
      active_q <= '0;
    end else begin
      if (xfer && bus_write && (region == region_reg))
        shadow_q[bus_addr[1:0]] <= bus_wdata;
      if (vsync_start)
        active_q <= shadow_q;
    end
  end

  assign ctl_mode     = active_q[reg_mode];
  assign ctl_bm_color = active_q[reg_bm_color];
  assign ctl_window   = active_q[reg_window];
  assign ctl_ch_color = active_q[reg_ch_color];

  ////////////////////////////////
  // Read data, BGM word arrives one cycle after the transfer

  always_ff @(posedge CLK) begin
    if (reset) begin
      rd_pend_q  <= 1'b0;
      bus_rvalid <= 1'b0;
    end else begin
      rd_pend_q  <= xfer & ~bus_write;
      bus_rvalid <= rd_pend_q;
    end
  end

  always_ff @(posedge CLK) begin
    rd_region_q <= region;
    rd_lane_q   <= bus_addr[1:0];
    bus_rdata   <= (rd_region_q == region_bgm) ? bgm_host_rdata[rd_lane_q*8 +: 8]
                                               : reg_read_value;  // Regs read back as 0xFF
  end

endmodule

`default_nettype wire

//--- logic/bg_memory.sv
/*
  Background memories.
  128 x 32-bit BGM with one port shared by host and renderer,
  byte-wise host writes. 1 KB character ROM loaded through its
  own write port, registered read.
*/
`default_nettype none
`timescale 1ns/100ps

module bg_memory import host_bus_pkg::*; (
  input  wire                   CLK,
  input  wire                   bgm_host_en,
  input  wire [bgm_addr_w-1:0]  bgm_host_addr,
  input  wire [3:0]             bgm_host_we,
  input  wire [7:0]             bgm_host_wdata,
  output logic [31:0]           bgm_host_rdata,
  input  wire [bgm_addr_w-1:0]  bgm_fetch_addr,
  output logic [31:0]           bgm_fetch_data,
  input  wire [chr_addr_w-1:0]  chr_addr,
  output logic [7:0]            chr_data,
  input  wire                   rom_valid,
  input  wire [chr_addr_w-1:0]  rom_addr,
  input  wire [7:0]             rom_data
);

  logic [31:0]           bgm [bgm_words];
  logic [7:0]            chr_rom [chr_depth];
  logic [bgm_addr_w-1:0] bgm_addr;
  logic [3:0]            bgm_we;
  logic [31:0]           bgm_rd_q;

  // Host wins the port whenever it has a transfer
  assign bgm_addr = bgm_host_en ? bgm_host_addr : bgm_fetch_addr;
  assign bgm_we   = bgm_host_en ? bgm_host_we : 4'b0000;

  always_ff @(posedge CLK) begin
    bgm_rd_q <= bgm[bgm_addr];
    for (int i = 0; i < 4; i++) begin
      if (bgm_we[i])
        bgm[bgm_addr][i*8 +: 8] <= bgm_host_wdata;
    end
  end

  assign bgm_host_rdata = bgm_rd_q;  // Same word, owner set by last cycle
  assign bgm_fetch_data = bgm_rd_q;

  ////////////////////////////////
  // Character ROM

  always_ff @(posedge CLK) begin
    if (rom_valid)
      chr_rom[rom_addr] <= rom_data;
    chr_data <= chr_rom[chr_addr];
  end

endmodule

`default_nettype wire

//--- logic/bg_renderer.sv
/*
  Background renderer.
  Fetches the BGM byte and character pattern for the next 8-pixel
  cell, chooses character or bitmap by the window split, and shifts
  the cell out one pixel per clock. Pixel for a raster position
  appears two cycles after it.
*/
`default_nettype none
`timescale 1ns/100ps

module bg_renderer import video_timing_pkg::*, host_bus_pkg::*; (
  input  wire                   CLK,
  input  wire raster_t          row,
  input  wire raster_t          col,
  input  wire [7:0]             ctl_mode,
  input  wire [7:0]             ctl_bm_color,
  input  wire [7:0]             ctl_window,
  input  wire [7:0]             ctl_ch_color,
  output logic [bgm_addr_w-1:0] bgm_fetch_addr,
  input  wire [31:0]            bgm_fetch_data,
  output logic [chr_addr_w-1:0] chr_addr,
  input  wire [7:0]             chr_data,
  output color_idx_t            pixel
);

  logic [2:0]  phase;
  logic [4:0]  tx_next, ty;
  logic        is_char;
  logic [7:0]  cell_byte, bm_pat, char_pat;
  logic [1:0]  hires_bits;
  logic [3:0]  lores_nib;
  color_idx_t  bm_fg;
  logic        cell_char_q, char_blank_q;
  logic [7:0]  bm_pat_q, pend_pat_q, shift_q;
  color_idx_t  fg_q, bg_q, cur_fg_q, cur_bg_q;

  // Phase 3 fetch BGM, phase 4 fetch pattern, phase 1 load shifter
  assign phase   = col[2:0];
  assign tx_next = col[7:3] + 5'd1;
  assign ty      = row[7:3];

  assign is_char = (((tx_next[4:1] < ctl_window[xmax_lsb +: 4]) ^ ctl_mode[invert_x_bit]) &
                    ((ty[4:1] < ctl_window[ymax_lsb +: 4]) ^ ctl_mode[invert_y_bit]));

  assign bgm_fetch_addr = {ty[4:1], tx_next[4:2]};
  assign cell_byte      = bgm_fetch_data[tx_next[1:0]*8 +: 8];
  assign chr_addr       = {cell_byte[6:0], row[2:0]};

  assign hires_bits = cell_byte[{~row[3:2], 1'b0} +: 2];
  assign lores_nib  = cell_byte[{~row[3], 2'b00} +: 4];

  // Bitmap decode, bit 0 of a pattern is the leftmost pixel
  always_comb begin
    bm_pat = 8'h00;
    bm_fg  = ctl_bm_color[fg_nibble_lsb +: 4];
    if (ctl_mode[bm_enable_bit]) begin
      if (ctl_mode[bm_lores_bit]) begin
        if (lores_nib != 4'd0) begin  // Zero is transparent
          bm_pat = 8'hFF;
          bm_fg  = lores_nib;
        end
      end else begin
        bm_pat = {{4{hires_bits[0]}}, {4{hires_bits[1]}}};
      end
    end
  end

  // ROM bits 7:2 map to pixels 2..7, odd rows of cells stay blank
  always_comb begin
    char_pat = 8'h00;
    if (!char_blank_q) begin
      for (int k = 2; k < 8; k++)
        char_pat[k] = chr_data[9-k];
    end
  end

  always_ff @(posedge CLK) begin
    if (phase == 3'd4) begin
      cell_char_q  <= is_char;
      char_blank_q <= ty[0];
      bm_pat_q     <= bm_pat;
      fg_q         <= is_char ? ctl_ch_color[fg_nibble_lsb +: 4] : bm_fg;
      bg_q         <= is_char ? ctl_ch_color[bg_nibble_lsb +: 4]
                              : ctl_bm_color[bg_nibble_lsb +: 4];
    end
    if (phase == 3'd5)
      pend_pat_q <= cell_char_q ? char_pat : bm_pat_q;
    if (phase == 3'd1) begin
      shift_q  <= pend_pat_q;
      cur_fg_q <= fg_q;
      cur_bg_q <= bg_q;
    end else begin
      shift_q  <= {1'b0, shift_q[7:1]};
    end
  end

  assign pixel = shift_q[0] ? cur_fg_q : cur_bg_q;

endmodule

`default_nettype wire

//--- logic/color_gen.sv
/*
  Colour generator.
  Forces the border colour outside the render window and maps the
  palette index to 24-bit RGB, one register stage.
*/
`default_nettype none
`timescale 1ns/100ps

module color_gen import video_timing_pkg::*; (
  input  wire              CLK,
  input  wire color_idx_t  pixel,
  input  wire              render_px,
  output rgb_t             rgb
);

  color_idx_t idx;

  assign idx = render_px ? pixel : border_color;  // Black border

  always_ff @(posedge CLK) begin
    rgb <= palette[idx];
  end

endmodule

`default_nettype wire

//--- logic/scv_video.sv
/*
  Background video display processor, top level.
  Connects raster timing, host port, background memories,
  background renderer and colour generator.
*/
`default_nettype none
`timescale 1ns/100ps

module scv_video import video_timing_pkg::*, host_bus_pkg::*; (
  input  wire                   CLK,
  input  wire                   reset,
  // Host port
  input  wire                   bus_valid,
  output logic                  bus_ready,
  input  wire                   bus_write,
  input  wire addr_t            bus_addr,
  input  wire [7:0]             bus_wdata,
  output logic                  bus_rvalid,
  output logic [7:0]            bus_rdata,
  // Character ROM load
  input  wire                   rom_valid,
  input  wire [chr_addr_w-1:0]  rom_addr,
  input  wire [7:0]             rom_data,
  // Video out
  output rgb_t                  rgb,
  output logic                  de,
  output logic                  hs,
  output logic                  vs,
  output logic                  vbl
);

  raster_t                 row;
  raster_t                 col;
  logic                    vsync_start;
  logic                    render_px;
  logic                    bgm_host_en;
  logic [bgm_addr_w-1:0]   bgm_host_addr;
  logic [3:0]              bgm_host_we;
  logic [7:0]              bgm_host_wdata;
  logic [31:0]             bgm_host_rdata;
  logic [bgm_addr_w-1:0]   bgm_fetch_addr;
  logic [31:0]             bgm_fetch_data;
  logic [chr_addr_w-1:0]   chr_addr;
  logic [7:0]              chr_data;
  logic [7:0]              ctl_mode;
  logic [7:0]              ctl_bm_color;
  logic [7:0]              ctl_window;
  logic [7:0]              ctl_ch_color;
  color_idx_t              pixel;

  raster_timing u_raster (.*);

  host_port u_host (.*);

  bg_memory u_memory (.*);

  bg_renderer u_renderer (.*);

  color_gen u_color (.*);

endmodule

`default_nettype wire

//--- testbench/scv_video_asserts.sv
/*
  Concurrent checks on the host handshake and the sync outputs
  of the background video processor.
*/
`default_nettype none
`timescale 1ns/100ps

module scv_video_asserts import host_bus_pkg::*; (
  input wire        CLK,
  input wire        reset,
  input wire        bus_valid,
  input wire        bus_ready,
  input wire        bus_write,
  input wire addr_t bus_addr,
  input wire [7:0]  bus_wdata,
  input wire        bus_rvalid,
  input wire        de,
  input wire        hs
);

  // Stalled request holds until taken
  request_held: assert property (@(posedge CLK) disable iff (reset)
    bus_valid && !bus_ready |=> bus_valid && $stable(bus_addr) &&
                                $stable(bus_write) && $stable(bus_wdata))
    else $error("host request changed while stalled");

  read_latency: assert property (@(posedge CLK) disable iff (reset)
    bus_valid && bus_ready && !bus_write |-> ##2 bus_rvalid)
    else $error("read data not valid two cycles after transfer");

  no_hs_in_active: assert property (@(posedge CLK) disable iff (reset) !(hs && de))
    else $error("HS high during active display");

endmodule

bind scv_video scv_video_asserts u_asserts (.*);

`default_nettype wire

//--- testbench/tb_scv_video.sv
/*
  Testbench for the background video processor.
  Mirrors ROM, BGM and control registers, predicts RGB and sync
  for every raster position and checks host reads.
*/
`default_nettype none
`timescale 1ns/100ps

module tb_scv_video import video_timing_pkg::*, host_bus_pkg::*; ();

  localparam longint frame_cycles = 263 * 260;
  localparam longint watchdog_ns  = 7 * frame_cycles * 20;  // Five frames run, two spare

  logic CLK = 1'b0;
  logic reset, bus_valid, bus_write, rom_valid, bus_ready, bus_rvalid;
  addr_t bus_addr;
  logic [7:0] bus_wdata, rom_data, bus_rdata;
  logic [chr_addr_w-1:0] rom_addr;
  rgb_t rgb;
  logic de, hs, vs, vbl;

  logic [7:0] rom_m [chr_depth];
  logic [7:0] bgm_m [bgm_words*4];   // Byte addressed
  logic [7:0] shadow_m [4];
  logic [7:0] active_m [4];
  logic [15:0] lfsr = 16'd19948;
  int tb_row, tb_col;
  int unsigned cyc;
  rgb_t exp_rgb [4];
  logic exp_de [4], exp_hs [4], exp_vs [4], exp_vbl [4];

  scv_video uut (.*);

  always #10 CLK = ~CLK;

  ////////////////////////////////
  // Helpers

  function automatic logic [7:0] rand_bits(int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_rgb(rgb_t got, rgb_t exp, string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "rgb mismatch");
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "sync mismatch");
    end
  endtask

  task automatic check_byte(logic [7:0] got, logic [7:0] exp, string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "read mismatch");
    end
  endtask

  function automatic logic in_window(int r, int c);
    return r >= first_row_render && r <= last_row_render &&
           c >= first_col_render && c <= last_col_render;
  endfunction

  // Expected colour for one raster position
  function automatic rgb_t expected_rgb(int r, int c);
    int tx, ty, k;
    logic [7:0] b, m, bmc, win, ch, pat;
    logic is_char, lit;
    logic [1:0] pair;
    color_idx_t fg, bg, nib;
    if (!in_window(r, c))
      return palette[border_color];
    tx = c / 8;
    ty = r / 8;
    k = c % 8;
    m = active_m[0];
    bmc = active_m[1];
    win = active_m[2];
    ch = active_m[3];
    b = bgm_m[((ty / 2) * 8 + tx / 4) * 4 + tx % 4];
    is_char = (((tx / 2) < win[3:0]) ^ m[6]) && (((ty / 2) < win[7:4]) ^ m[7]);
    lit = 1'b0;
    if (is_char) begin
      fg = ch[7:4];
      bg = ch[3:0];
      pat = rom_m[b[6:0] * 8 + r % 8];
      if (k >= 2 && ty % 2 == 0)
        lit = pat[9 - k];
    end else begin
      fg = bmc[7:4];
      bg = bmc[3:0];
      if (m[0] && m[1]) begin
        nib = ((r / 8) % 2) ? b[3:0] : b[7:4];  // Row bit 3 clear picks high nibble
        if (nib != 4'd0) begin
          fg = nib;
          lit = 1'b1;
        end
      end else if (m[0]) begin
        pair = b[6 - 2 * ((r / 4) % 4) +: 2];
        lit = (k < 4) ? pair[1] : pair[0];
      end
    end
    return palette[lit ? fg : bg];
  endfunction

  ////////////////////////////////
  // Compare at pipe_latency lag, sampled on the falling edge

  always @(negedge CLK) begin
    int slot, old;
    if (!reset) begin
      slot = cyc % 4;
      if (cyc >= pipe_latency) begin
        old = (cyc - pipe_latency) % 4;
        check_rgb(rgb, exp_rgb[old], "rgb");
        check_bit(de, exp_de[old], "de");
        check_bit(hs, exp_hs[old], "hs");
        check_bit(vs, exp_vs[old], "vs");
        check_bit(vbl, exp_vbl[old], "vbl");
      end
      exp_rgb[slot] = expected_rgb(tb_row, tb_col);
      exp_de[slot]  = in_window(tb_row, tb_col);
      exp_hs[slot]  = tb_col >= first_col_hsync && tb_col <= last_col_hsync;
      exp_vs[slot]  = tb_row >= first_row_vsync && tb_row <= last_row_vsync;
      exp_vbl[slot] = !(tb_row >= first_row_render && tb_row <= last_row_render);
      if (tb_row == first_row_vsync && tb_col == 0)
        active_m = shadow_m;  // Shadow goes live
      tb_col = (tb_col == num_cols - 1) ? 0 : tb_col + 1;
      if (tb_col == 0)
        tb_row = (tb_row == num_rows - 1) ? 0 : tb_row + 1;
      cyc++;
    end
  end

  ////////////////////////////////
  // Stimulus tasks

  task automatic wait_pos(int r, int c);
    do @(posedge CLK); while (!(tb_row == r && tb_col == c));
  endtask

  task automatic host_access(logic write, addr_t addr, logic [7:0] wdata);
    int waited;
    logic accepted;
    @(posedge CLK);
    bus_valid <= 1'b1;
    bus_write <= write;
    bus_addr  <= addr;
    bus_wdata <= wdata;
    accepted = 1'b0;
    waited = 0;
    while (!accepted) begin
      @(negedge CLK);
      accepted = bus_ready;
      @(posedge CLK);
      waited++;
      if (waited > 16)
        fail_run("Host port never raised ready");
    end
    bus_valid <= 1'b0;
    if (write) begin
      if (addr[12:9] == bgm_page)
        bgm_m[addr[8:0]] = wdata;
      else if (addr[12:9] == reg_page)
        shadow_m[addr[1:0]] = wdata;
    end else begin
      waited = 0;
      do begin
        @(negedge CLK);
        waited++;
        if (waited > 4)
          fail_run("Read data never became valid");
      end while (!bus_rvalid);
      check_byte(bus_rdata, (addr[12:9] == bgm_page) ? bgm_m[addr[8:0]] : reg_read_value,
                 "host read");
    end
  endtask

  task automatic write_regs(logic [7:0] m, logic [7:0] bmc, logic [7:0] win,
                            logic [7:0] ch);
    host_access(1'b1, 13'h1400, m);
    host_access(1'b1, 13'h1401, bmc);
    host_access(1'b1, 13'h1402, win);
    host_access(1'b1, 13'h1403, ch);
  endtask

  task automatic load_rom();
    logic [7:0] b;
    for (int i = 0; i < chr_depth; i++) begin
      @(posedge CLK);
      b = rand_bits(8);
      rom_valid <= 1'b1;
      rom_addr  <= i[chr_addr_w-1:0];
      rom_data  <= b;
      rom_m[i] = b;
    end
    @(posedge CLK);
    rom_valid <= 1'b0;
  endtask

  ////////////////////////////////
  // Main sequence

  initial begin
    logic [7:0] offset_hi, offset_lo;
    reset = 1'b1;
    bus_valid = 1'b0;
    bus_write = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    rom_valid = 1'b0;
    rom_addr = '0;
    rom_data = '0;
    tb_row = 0;
    tb_col = 0;
    cyc = 0;
    for (int i = 0; i < 4; i++) begin
      shadow_m[i] = 8'h00;
      active_m[i] = 8'h00;
    end
    repeat (2) @(posedge CLK);
    reset <= 1'b0;

    // Frame 0 all bitmap off, only sync and border matter
    wait_pos(248, 0);
    write_regs(8'h00, rand_bits(8), 8'hFF, rand_bits(8));  // All character cells
    load_rom();
    for (int i = 0; i < bgm_words * 4; i++)
      host_access(1'b1, 13'h1000 + i[12:0], rand_bits(8));

    // Frame 1 characters, then low-res bitmap with zero nibbles
    wait_pos(248, 0);
    write_regs(8'h03, rand_bits(8), 8'h00, shadow_m[3]);
    host_access(1'b1, 13'h1000 + 13'd34, 8'h07);
    host_access(1'b1, 13'h1000 + 13'd35, 8'h50);
    host_access(1'b1, 13'h1000 + 13'd40, 8'h00);

    // Frame 2 low-res, then high-res split with both inverts
    wait_pos(248, 0);
    write_regs(8'hC1, rand_bits(8), 8'h85, rand_bits(8));

    // Frame 3 reads under back-pressure, then a mid-frame register write
    wait_pos(100, 0);
    for (int i = 0; i < 24; i++) begin
      offset_hi = rand_bits(8);
      offset_lo = rand_bits(1);
      host_access(1'b0, {bgm_page, offset_hi, offset_lo[0]}, 8'h00);
    end
    for (int i = 0; i < 4; i++)
      host_access(1'b0, 13'h1400 + i[12:0], 8'h00);
    host_access(1'b0, 13'h0000, 8'h00);
    host_access(1'b1, 13'h1403, ~shadow_m[3]);
    host_access(1'b1, 13'h1402, 8'h58);

    // Frame 3 must stay unchanged, frame 4 shows the new values
    wait_pos(248, 0);
    wait_pos(248, 0);
    $display("No errors");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the test sequence did not finish in time");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- build.f
logic/video_timing_pkg.sv
logic/host_bus_pkg.sv
logic/raster_timing.sv
logic/host_port.sv
logic/bg_memory.sv
logic/bg_renderer.sv
logic/color_gen.sv
logic/scv_video.sv
testbench/scv_video_asserts.sv
testbench/tb_scv_video.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the background video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_scv_video -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_scv_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
